// File: life_engine.f
+incdir+sim
design/life_pkg.sv
design/row_store.sv
design/life_gen_stage.sv
design/life_pipeline.sv
design/life_engine.sv
sim/life_engine_tb.sv

// File: Makefile
# Verilator build and run of the life engine testbench

TOP = life_engine_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/1ps -f life_engine.f \
		--top-module $(TOP) -Mdir obj_dir

# pass only if the simulation prints the pass line
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir

// File: sim/life_model.svh
/* Reference life on an H-row by COLS torus, eight-neighbour B3/S23 rule.
   Included inside the testbench module; needs H, src_img and exp_img. */

`ifndef LIFE_MODEL_SVH
`define LIFE_MODEL_SVH

	life_pkg::row_t model_img [H];	// working generation
	life_pkg::row_t model_tmp [H];	// next generation under construction

	// three cells stacked around (r, c), wrap on both axes
	function automatic life_pkg::col_sum_t vert_count(input int r, input int c);
		int cc;
		int up;
		int dn;
		cc = (c + life_pkg::COLS) % life_pkg::COLS;
		up = (r + H - 1) % H;
		dn = (r + 1) % H;
		return life_pkg::col_sum_t'(model_img[up][cc]) +
		       life_pkg::col_sum_t'(model_img[r][cc]) +
		       life_pkg::col_sum_t'(model_img[dn][cc]);
	endfunction

	// one generation of the whole image
	task automatic model_generation();
		int n;	// live neighbours, centre left out
		for (int r = 0; r < H; r++) begin
			for (int c = 0; c < life_pkg::COLS; c++) begin
				n = int'(vert_count(r, c - 1)) + int'(vert_count(r, c)) +
				    int'(vert_count(r, c + 1)) - int'(model_img[r][c]);
				model_tmp[r][c] = (n == 3) || ((n == 2) && model_img[r][c]);
			end
		end
		for (int r = 0; r < H; r++) begin
			model_img[r] = model_tmp[r];
		end
	endtask

	// exp_img = src_img advanced by gens generations
	task automatic expect_generations(input int gens);
		for (int r = 0; r < H; r++) model_img[r] = src_img[r];
		repeat (gens) model_generation();
		for (int r = 0; r < H; r++) exp_img[r] = model_img[r];
	endtask

`endif

// File: sim/life_engine_tb.sv
/* Testbench for the linear life engine. The image is H = ROWS/2 rows:
   passes read the lower half of the store and write results to the upper half.
   Inputs change 1 ns after the rising edge; stops at the first mismatch. */

`timescale 1ns/1ps

module life_engine_tb;

	//////////////////////////////////////////////////////////////////////
	// pass geometry
	//////////////////////////////////////////////////////////////////////

	localparam int H          = life_pkg::ROWS / 2;	// torus height
	localparam int DST_BASE   = H;	// result half
	localparam int LEAD       = life_pkg::GENS;	// rows read before row 0, one per generation
	localparam int LAG        = 3 * life_pkg::GENS;	// steps from read to wr_row
	localparam int FIRST_OUT  = LAG + LEAD;	// step whose wr_row is result row 0
	localparam int PASS_STEPS = H + FIRST_OUT;
	localparam int PASSES     = 3;
	// five full readbacks, four loads and resets
	localparam int IO_CYCLES  = 7 * life_pkg::ROWS * 3;
	localparam int LIMIT      = 4 * (PASSES * (PASS_STEPS + 1) * 3 + IO_CYCLES);

	logic                clk;
	logic                reset;
	life_pkg::mem_ctrl_t mem_ctrl;
	logic                step;
	logic                ld;
	logic                init;
	life_pkg::row_t      init_data;
	life_pkg::row_t      dout;

	int seed;
	int cycles = 0;

	life_pkg::row_t src_img [H];	// image placed in the source half
	life_pkg::row_t exp_img [H];	// expected image after one pass
	life_pkg::row_t shadow [life_pkg::ROWS];	// expected store contents

	`include "life_model.svh"

	life_engine dut_i (
		.clk       (clk),
		.reset     (reset),
		.mem_ctrl  (mem_ctrl),
		.step      (step),
		.ld        (ld),
		.init      (init),
		.init_data (init_data),
		.dout      (dout)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	// hang guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			stop_with_failure("cycle limit reached, the run did not finish");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic tick();
		@(posedge clk);
		#1;	// drive point
	endtask

	task automatic check_row(input string what, input int a, input life_pkg::row_t got,
	                         input life_pkg::row_t want);
		assert (got == want) else
			stop_with_failure($sformatf("ERR %s row %0d: got %h expected %h",
			                            what, a, got, want));
	endtask

	// init path write, one row per cycle
	task automatic write_row(input int a, input life_pkg::row_t data);
		mem_ctrl.waddr = life_pkg::addr_t'(a);
		mem_ctrl.we    = 1'b1;
		init           = 1'b1;
		init_data      = data;
		tick();
		mem_ctrl.we = 1'b0;
		init        = 1'b0;
	endtask

	// ld with the address, dout valid two edges later
	task automatic read_and_check(input int a, input life_pkg::row_t want);
		mem_ctrl.raddr = life_pkg::addr_t'(a);
		ld             = 1'b1;
		tick();
		ld = 1'b0;
		tick();
		tick();
		check_row("dout", a, dout, want);
	endtask

	task automatic check_store();
		for (int r = 0; r < life_pkg::ROWS; r++) read_and_check(r, shadow[r]);
	endtask

	// src_img to the source half, random fill above it
	task automatic load_image();
		for (int r = 0; r < life_pkg::ROWS; r++) begin
			if (r < H) shadow[r] = src_img[r];
			else shadow[r] = life_pkg::row_t'($random(seed));
			write_row(r, shadow[r]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one pass: reads wrap around the source half, writes trail by LAG
	//////////////////////////////////////////////////////////////////////

	task automatic run_pass(input bit stalls);
		int             idle;
		int             done;	// step whose wr_row is written now
		int             src;	// source row read this step
		int             held_addr;
		bit             show;
		bit             shown;
		life_pkg::row_t held;	// row last latched into dout
		shown     = 1'b0;
		held      = '0;
		held_addr = 0;
		for (int k = 0; k <= PASS_STEPS; k++) begin
			done = k - 1;
			src  = (k - LEAD + H) % H;
			show = (k < PASS_STEPS) && (($random(seed) & 3) == 0);
			mem_ctrl.raddr = life_pkg::addr_t'(src);
			mem_ctrl.waddr = life_pkg::addr_t'(DST_BASE + done - FIRST_OUT);
			mem_ctrl.we    = (done >= FIRST_OUT);
			step           = (k < PASS_STEPS);	// last round only writes
			ld             = show;
			tick();
			step        = 1'b0;
			ld          = 1'b0;
			mem_ctrl.we = 1'b0;
			tick();
			tick();	// enable edge of this step has passed
			if (show) begin
				held      = src_img[src];
				held_addr = src;
				shown     = 1'b1;
			end
			if (shown) check_row("dout", held_addr, dout, held);	// latch and hold
			if (stalls) begin
				idle = $random(seed) & 3;
				repeat (idle) tick();
			end
		end
		for (int r = 0; r < H; r++) shadow[DST_BASE + r] = exp_img[r];
	endtask

	//////////////////////////////////////////////////////////////////////
	// sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed           = 32'h975db809;
		reset          = 1'b1;
		mem_ctrl       = '0;
		step           = 1'b0;
		ld             = 1'b0;
		init           = 1'b0;
		init_data      = '0;
		repeat (10) tick();
		reset = 1'b0;

		// init writes and full readback
		for (int r = 0; r < H; r++) src_img[r] = life_pkg::row_t'($random(seed));
		load_image();
		check_store();

		// reset again, step low: dout keeps the last row, no writes
		reset = 1'b1;
		repeat (10) tick();
		reset = 1'b0;
		repeat (8) tick();
		check_row("dout", life_pkg::ROWS - 1, dout, shadow[life_pkg::ROWS - 1]);
		check_store();

		// still lifes, one block wrapped over both edges
		for (int r = 0; r < H; r++) src_img[r] = '0;
		src_img[2][4]   = 1'b1;
		src_img[2][5]   = 1'b1;
		src_img[3][4]   = 1'b1;
		src_img[3][5]   = 1'b1;
		src_img[H-1][0] = 1'b1;
		src_img[H-1][life_pkg::COLS-1] = 1'b1;
		src_img[0][0]   = 1'b1;
		src_img[0][life_pkg::COLS-1]   = 1'b1;
		src_img[8][12]  = 1'b1;	// horizontal blinker
		src_img[8][13]  = 1'b1;
		src_img[8][14]  = 1'b1;
		src_img[11][24] = 1'b1;	// vertical blinker
		src_img[12][24] = 1'b1;
		src_img[13][24] = 1'b1;
		for (int r = 0; r < H; r++) exp_img[r] = src_img[r];	// period 1 or 2
		load_image();
		run_pass(1'b0);
		check_store();

		// random image against the model
		for (int r = 0; r < H; r++) src_img[r] = life_pkg::row_t'($random(seed));
		expect_generations(life_pkg::GENS);
		load_image();
		run_pass(1'b0);
		check_store();

		// same image with idle gaps between steps
		load_image();
		run_pass(1'b1);
		check_store();

		$display("TEST OK");
		$finish;
	end

endmodule

// File: design/life_engine.sv
/* Linear life engine top: row store plus generation pipeline.
   The external sequencer owns addresses, we and step; rows written back
   lag the reads by 3*GENS steps. */

`timescale 1ns/1ps

module life_engine (
	input  logic                clk,
	input  logic                reset,
	input  life_pkg::mem_ctrl_t mem_ctrl,	// read/write addresses, we
	input  logic                step,	// advance pipeline one row
	input  logic                ld,	// display latch request
	input  logic                init,	// select init_data for writes
	input  life_pkg::row_t      init_data,
	output life_pkg::row_t      dout	// display row
);

	life_pkg::row_t rd_row;	// store to pipeline
	life_pkg::row_t wr_row;	// pipeline back to store

	// memory, init mux, display tap
	row_store store_i (
		.clk       (clk),
		.reset     (reset),
		.mem_ctrl  (mem_ctrl),
		.init      (init),
		.init_data (init_data),
		.wr_row    (wr_row),
		.ld        (ld),
		.rd_row    (rd_row),
		.dout      (dout)
	);

	// GENS generations per pass
	life_pipeline pipe_i (
		.clk    (clk),
		.reset  (reset),
		.step   (step),
		.rd_row (rd_row),
		.wr_row (wr_row)
	);

endmodule

// File: design/life_pipeline.sv
/* Chain of GENS life stages on a common step enable.
   wr_row after step n is generation GENS of the row read at step n-3*GENS.
   No back-pressure; step low freezes every stage. */

`timescale 1ns/1ps

module life_pipeline (
	input  logic           clk,
	input  logic           reset,
	input  logic           step,	// one row per strobe
	input  life_pkg::row_t rd_row,	// memory read data
	output life_pkg::row_t wr_row	// last generation, to memory write
);

	//////////////////////////////////////////////////////////////////////
	// step enable
	//////////////////////////////////////////////////////////////////////

	logic [life_pkg::STEP_DELAY-1:0] step_del;	// waits out the read latency
	logic                            en;

	always_ff @(posedge clk) begin
		if (reset) begin
			step_del <= '0;
		end else begin
			step_del <= {step_del[life_pkg::STEP_DELAY-2:0], step};
		end
	end

	assign en = step_del[life_pkg::STEP_DELAY-1];	// shared by all stages

	//////////////////////////////////////////////////////////////////////
	// generation chain
	//////////////////////////////////////////////////////////////////////

	life_pkg::row_t [life_pkg::GENS:0] chain;	// chain[g] feeds stage g

	assign chain[0] = rd_row;

	for (genvar g = 0; g < life_pkg::GENS; g++) begin : gen_stage
		life_gen_stage stage_i (
			.clk      (clk),
			.en       (en),
			.row_in   (chain[g]),
			.row_next (chain[g+1])
		);
	end

	// output register, steady between steps for the write
	always_ff @(posedge clk) begin
		if (en) begin
			wr_row <= chain[life_pkg::GENS];
		end
	end

endmodule

// File: design/life_gen_stage.sv
/* One life generation over a full row, torus wrap across the columns.
   Moves only on en; window and sums are undefined until three rows are in.
   Output row is the successor of the window centre, two steps behind row_in. */

`timescale 1ns/1ps

module life_gen_stage (
	input  logic           clk,
	input  logic           en,	// shared step enable
	input  life_pkg::row_t row_in,	// previous generation or memory row
	output life_pkg::row_t row_next	// next generation, combinational
);

	//////////////////////////////////////////////////////////////////////
	// three-row window
	//////////////////////////////////////////////////////////////////////

	// win[0] newest, win[2] oldest
	life_pkg::row_t [2:0] win;

	always_ff @(posedge clk) begin
		if (en) begin
			win[2] <= win[1];
			win[1] <= win[0];
			win[0] <= row_in;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// column sums
	//////////////////////////////////////////////////////////////////////

	life_pkg::col_sum_t [life_pkg::COLS-1:0] col_sum;	// from current window
	life_pkg::col_sum_t [life_pkg::COLS-1:0] col_sum_q;	// centred on win[2] after en

	always_comb begin
		for (int c = 0; c < life_pkg::COLS; c++) begin
			col_sum[c] = {1'b0, win[2][c]} +
			             {1'b0, win[1][c]} +
			             {1'b0, win[0][c]};	// 0..3
		end
	end

	// registered on the same enable as the shift, so the centre of the
	// summed window lands in win[2]
	always_ff @(posedge clk) begin
		if (en) begin
			col_sum_q <= col_sum;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// nine-cell count and rule
	//////////////////////////////////////////////////////////////////////

	logic [life_pkg::COLS-1:0][3:0] cnt;	// includes the centre cell, 0..9

	always_comb begin
		for (int c = 0; c < life_pkg::COLS; c++) begin
			cnt[c] = {2'b00, col_sum_q[(c == 0) ? life_pkg::COLS-1 : c-1]} +	// wrap left
			         {2'b00, col_sum_q[c]} +
			         {2'b00, col_sum_q[(c == life_pkg::COLS-1) ? 0 : c+1]};	// wrap right
		end
	end

	always_comb begin
		for (int c = 0; c < life_pkg::COLS; c++) begin
			// 3 total, alive with 2 neighbours or born with 3
			// 4 total, survives only if centre is alive
			row_next[c] = (cnt[c] == 4'd3) ||
			              ((cnt[c] == 4'd4) && win[2][c]);
		end
	end

endmodule

// File: design/row_store.sv
/* Two-port row memory, registered address and registered read data.
   A read address gives data two edges later; same-row read during a write
   returns the old row. Memory contents and dout are not reset. */

`timescale 1ns/1ps

module row_store (
	input  logic                clk,
	input  logic                reset,
	input  life_pkg::mem_ctrl_t mem_ctrl,	// raddr, waddr, we
	input  logic                init,	// write init_data instead of wr_row
	input  life_pkg::row_t      init_data,
	input  life_pkg::row_t      wr_row,	// computed row from the pipeline
	input  logic                ld,	// display load pulse
	output life_pkg::row_t      rd_row,
	output life_pkg::row_t      dout	// display tap
);

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	life_pkg::row_t  mem [life_pkg::ROWS];
	life_pkg::addr_t raddr_q;	// address register
	life_pkg::row_t  wdata;	// write data after init mux
	logic [1:0]      ld_del;	// ld delay line, matches read latency

	// init path overrides the computed row
	assign wdata = init ? init_data : wr_row;

	// write port
	always_ff @(posedge clk) begin
		if (mem_ctrl.we) begin
			mem[mem_ctrl.waddr] <= wdata;
		end
	end

	// read port, address then data registered
	always_ff @(posedge clk) begin
		raddr_q <= mem_ctrl.raddr;	// first stage
		rd_row  <= mem[raddr_q];	// second stage, old data on collision
	end

	//////////////////////////////////////////////////////////////////////
	// display tap
	//////////////////////////////////////////////////////////////////////

	// ld follows the address through both read stages
	always_ff @(posedge clk) begin
		if (reset) begin
			ld_del <= '0;
		end else begin
			ld_del <= {ld_del[0], ld};
		end
	end

	// latch the row that was addressed alongside ld
	always_ff @(posedge clk) begin
		if (ld_del[1]) begin
			dout <= rd_row;	// holds until next load
		end
	end

endmodule

// File: design/life_pkg.sv
/* Shared sizes and types for the linear life engine.
   COLS is the datapath width and ROWS the image height; ABITS must cover ROWS.
   STEP_DELAY has to track the row memory read latency. */

package life_pkg;

	//////////////////////////////////////////////////////////////////////
	// image geometry
	//////////////////////////////////////////////////////////////////////

	localparam int COLS  = 32;	// cells per row, one bit each
	localparam int ROWS  = 32;	// rows in the torus
	localparam int ABITS = 5;	// log2(ROWS)

	//////////////////////////////////////////////////////////////////////
	// pipeline shape
	//////////////////////////////////////////////////////////////////////

	localparam int GENS       = 2;	// generations per pass
	localparam int STEP_DELAY = 2;	// step to window update, matches read latency

	// one image row, bit set means alive
	typedef logic [COLS-1:0] row_t;

	typedef logic [ABITS-1:0] addr_t;	// row address

	// vertical count of three cells, 0..3
	typedef logic [1:0] col_sum_t;

	// sequencer controls for the row store
	typedef struct packed {
		addr_t raddr;	// read row, registered in the store
		addr_t waddr;	// write row
		logic  we;	// write strobe
	} mem_ctrl_t;

endpackage
